//--- bch_consts.svh
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// Binary BCH(15,7) with two-error correction over GF(16)

// Width of one field element in bits
`define BCH_M 4

// Code word length, which is also the multiplicative order of alpha
`define BCH_N 15

// Number of message bits carried in each code word
`define BCH_K 7

// Primitive polynomial x^4 + x + 1, with the x^4 term included
`define BCH_POLY 5'b10011

// Cycles from sampling a message bit to seeing it corrected on dout.
// It breaks down as 14 bits left in the frame, 1 for the syndromes,
// 1 for the locator, 1 for the Chien evaluation and 1 for the output register
`define BCH_DELAY 18

`endif

//--- bchPkg.sv
`default_nettype none

`include "bch_consts.svh"

package bchPkg;

	// One element of GF(16) in polynomial basis
	typedef logic [`BCH_M-1:0] gfElem;

	// Full field polynomial; only the low bits take part in the reduction
	localparam logic [`BCH_M:0] fieldPoly = `BCH_POLY;

	// The primitive element alpha is the polynomial x
	localparam gfElem gfAlpha = gfElem'(2);

	// Shift-and-add product of two field elements
	function automatic gfElem gfMul(input gfElem a, input gfElem b);
		gfElem acc;
		gfElem sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ sh; // Add this partial product
			// Multiply sh by x and fold the carry back in
			sh = {sh[`BCH_M-2:0], 1'b0} ^ (sh[`BCH_M-1] ? fieldPoly[`BCH_M-1:0] : gfElem'(0));
		end
		return acc;
	endfunction

	// Alpha to any integer power, negative exponents included
	function automatic gfElem gfAlphaPow(input int e);
		int r;
		gfElem p;
		r = ((e % `BCH_N) + `BCH_N) % `BCH_N; // Bring the exponent into 0..14
		p = gfElem'(1);
		for (int i = 0; i < `BCH_N - 1; i++) begin
			if (i < r)
				p = gfMul(p, gfAlpha);
		end
		return p;
	endfunction

endpackage

`default_nettype wire

//--- locatorIf.sv
`timescale 1ns/10ps
`default_nettype none

// Error-locator coefficients handed from the solver to the Chien search
interface locatorIf;
	import bchPkg::*;

	logic start; // One-cycle pulse, coefficients are valid from here on
	gfElem lam0; // Constant term, S1
	gfElem lam1; // Linear term, S1 squared
	gfElem lam2; // Quadratic term, S3 + S1 cubed

	modport solver (
		output start,
		output lam0,
		output lam1,
		output lam2
	);

	modport search (
		input start,
		input lam0,
		input lam1,
		input lam2
	);

endinterface

`default_nettype wire

//--- syndromeCalc.sv
`timescale 1ns/10ps
`default_nettype none

`include "bch_consts.svh"

// Serial syndrome computation for one frame at a time.
// The received polynomial r(x) arrives highest power first, so each syndrome
// is built by Horner's rule: acc = acc * beta + bit, with beta = alpha or alpha^3
module syndromeCalc (
	input wire logic clk,
	input wire logic rst,
	input wire logic din,
	input wire logic inValid,
	output logic synValid,
	output bchPkg::gfElem s1,
	output bchPkg::gfElem s3
);
	import bchPkg::*;

	localparam gfElem alpha3 = gfAlphaPow(3);
	localparam logic [3:0] lastPos = 4'(`BCH_N - 1);

	logic [3:0] pos;  // Bit position within the current frame
	gfElem acc1;      // Partial r(alpha)
	gfElem acc3;      // Partial r(alpha^3)
	gfElem next1;
	gfElem next3;
	logic lastBit;

	// One Horner step per valid bit, the new bit lands in the constant term
	assign next1 = gfMul(acc1, gfAlpha) ^ gfElem'(din);
	assign next3 = gfMul(acc3, alpha3) ^ gfElem'(din);

	// The fifteenth bit closes the frame
	assign lastBit = inValid && (pos == lastPos);

	always_ff @(posedge clk) begin
		if (rst) begin
			pos <= '0;
			acc1 <= '0;
			acc3 <= '0;
			synValid <= 1'b0;
		end else begin
			synValid <= lastBit; // Pulse in the cycle after the last bit
			if (lastBit) begin
				// Clear right away so a following frame can start next cycle
				pos <= '0;
				acc1 <= '0;
				acc3 <= '0;
			end else if (inValid) begin
				pos <= pos + 4'd1;
				acc1 <= next1;
				acc3 <= next3;
			end
		end
	end

	// Finished syndromes, held until the next frame ends
	always_ff @(posedge clk) begin
		if (lastBit) begin
			s1 <= next1;
			s3 <= next3;
		end
	end

endmodule

`default_nettype wire

//--- locatorSolve.sv
`timescale 1ns/10ps
`default_nettype none

// Builds the error locator straight from S1 and S3.
//
// For error locations X1 and X2 the locator is
//   (1 + X1 x)(1 + X2 x) = 1 + S1 x + (S3/S1 + S1^2) x^2
// Scaling every coefficient by S1 removes the division:
//   S1 + S1^2 x + (S3 + S1^3) x^2
// The roots are unchanged. With one error S3 = S1^3, so the quadratic term
// vanishes, and with no errors all three coefficients are zero
module locatorSolve (
	input wire logic clk,
	input wire logic rst,
	input wire logic synValid,
	input wire bchPkg::gfElem s1,
	input wire bchPkg::gfElem s3,
	locatorIf.solver loc
);
	import bchPkg::*;

	gfElem s1Sq;
	gfElem s1Cube;
	gfElem quadTerm;

	assign s1Sq = gfMul(s1, s1);
	assign s1Cube = gfMul(s1Sq, s1);
	assign quadTerm = s3 ^ s1Cube; // Addition in GF(2^m) is XOR

	// Start trails synValid by one cycle
	always_ff @(posedge clk) begin
		if (rst)
			loc.start <= 1'b0;
		else
			loc.start <= synValid;
	end

	// Coefficients stay put until the next frame's syndromes arrive
	always_ff @(posedge clk) begin
		if (synValid) begin
			loc.lam0 <= s1;
			loc.lam1 <= s1Sq;
			loc.lam2 <= quadTerm;
		end
	end

endmodule

`default_nettype wire

//--- chienCorrect.sv
`timescale 1ns/10ps
`default_nettype none

`include "bch_consts.svh"

// Chien search over the message positions 14 down to 8 and correction of the
// received bits as they leave the delay line.
//
// An error at position p makes alpha^-p a root of the locator, so position p
// is tested by evaluating lam0 + lam1 * alpha^-p + lam2 * alpha^-2p.
// Going from p to p-1 scales the linear term by alpha and the quadratic term
// by alpha^2, which keeps every step down to a constant multiply
module chienCorrect (
	input wire logic clk,
	input wire logic rst,
	input wire logic din,
	locatorIf.search loc,
	output logic dout,
	output logic outValid
);
	import bchPkg::*;

	localparam int topPos = `BCH_N - 1;
	localparam gfElem firstStep1 = gfAlphaPow(-topPos);     // alpha^-14
	localparam gfElem firstStep2 = gfAlphaPow(-2 * topPos); // alpha^-28
	localparam gfElem alphaSq = gfAlphaPow(2);
	localparam logic [2:0] lastMsg = 3'(`BCH_K - 1);

	// With the output register this gives the full input-to-output delay
	logic [`BCH_DELAY-2:0] delayLine;

	gfElem term0; // Constant locator term
	gfElem term1; // Linear term at the current position
	gfElem term2; // Quadratic term at the current position
	gfElem evalSum;
	logic isRoot;
	logic delayedBit;
	logic active;       // High while the seven message positions are tested
	logic [2:0] posCnt; // Message bit under test, 0 is position 14

	// Every received bit goes through, parity included, so timing stays fixed
	always_ff @(posedge clk) begin
		delayLine <= {delayLine[`BCH_DELAY-3:0], din};
	end

	assign delayedBit = delayLine[`BCH_DELAY-2];

	assign evalSum = term0 ^ term1 ^ term2;

	// A zero locator means no errors; S1 is nonzero whenever one or two occurred
	assign isRoot = (evalSum == '0) && (term0 != '0);

	// Evaluation terms, loaded for position 14 and stepped once per position
	always_ff @(posedge clk) begin
		if (loc.start) begin
			term0 <= loc.lam0;
			term1 <= gfMul(loc.lam1, firstStep1);
			term2 <= gfMul(loc.lam2, firstStep2);
		end else if (active) begin
			term1 <= gfMul(term1, gfAlpha);
			term2 <= gfMul(term2, alphaSq);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			posCnt <= '0;
			outValid <= 1'b0;
			dout <= 1'b0;
		end else begin
			outValid <= active;
			dout <= active && (delayedBit ^ isRoot); // Flip the bit at a root
			if (loc.start) begin
				active <= 1'b1;
				posCnt <= '0;
			end else if (active) begin
				if (posCnt == lastMsg)
					active <= 1'b0; // Parity positions are never searched
				posCnt <= posCnt + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bchDecoder.sv
`timescale 1ns/10ps
`default_nettype none

// Serial BCH(15,7) decoder correcting up to two bit errors per frame.
// Frames of 15 bits come in with inValid high, message bits first;
// the 7 corrected message bits leave 18 cycles after they were sampled
module bchDecoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic din,
	input wire logic inValid,
	output logic dout,
	output logic outValid
);
	import bchPkg::*;

	logic synValid;
	gfElem s1;
	gfElem s3;

	locatorIf locBus ();

	// Syndromes of the next frame build up while the Chien stage
	// is still busy with the previous one
	syndromeCalc syndromeStage (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.inValid  (inValid),
		.synValid (synValid),
		.s1       (s1),
		.s3       (s3)
	);

	locatorSolve solveStage (
		.clk      (clk),
		.rst      (rst),
		.synValid (synValid),
		.s1       (s1),
		.s3       (s3),
		.loc      (locBus.solver)
	);

	// The Chien stage taps the raw input for its own delay line
	chienCorrect chienStage (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.loc      (locBus.search),
		.dout     (dout),
		.outValid (outValid)
	);

endmodule

`default_nettype wire

//--- tbBchDecoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "bch_consts.svh"

// Self-checking testbench for the serial BCH(15,7) decoder.
// Frames are encoded here, bits are flipped on purpose, and every message bit
// that goes in is expected back on dout exactly `BCH_DELAY cycles later
module tbBchDecoder;

	// Generator x^8 + x^7 + x^6 + x^4 + 1 without its leading term
	localparam logic [7:0] genLow = 8'hD1;
	localparam int drainLimit = `BCH_DELAY + 10;

	logic clk = 1'b0;
	logic rst;
	logic din;
	logic inValid;
	logic dout;
	logic outValid;

	int seed = 32'hb185_e5c1;
	int cycleCnt = 0; // Advances on every rising edge

	// Expected message bits, each tagged with the cycle it must appear in
	int dueCycleQ[$];
	logic dueBitQ[$];

	logic dueNow = 1'b0; // A message bit is expected in the current cycle
	logic dueBit = 1'b0;

	bchDecoder UUT (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.inValid  (inValid),
		.dout     (dout),
		.outValid (outValid)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	// Look up the expectation for the cycle that starts at this edge
	always @(posedge clk) begin
		if (dueCycleQ.size() > 0 && dueCycleQ[0] == cycleCnt + 1) begin
			dueNow <= 1'b1;
			dueBit <= dueBitQ.pop_front();
			void'(dueCycleQ.pop_front());
		end else begin
			dueNow <= 1'b0;
			dueBit <= 1'b0;
		end
	end

	task automatic stopRun();
		$display("Simulation FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	// Systematic encoder that appends the parity m(x) * x^8 mod g(x)
	function automatic logic [14:0] encodeWord(input logic [6:0] msg);
		logic [7:0] rem;
		logic [6:0] m;
		logic fb;
		rem = 8'h00;
		m = msg;
		for (int i = 0; i < `BCH_K; i++) begin
			fb = m[6] ^ rem[7]; // Highest message power enters first
			rem = {rem[6:0], 1'b0} ^ (fb ? genLow : 8'h00);
			m = m << 1;
		end
		return {msg, rem};
	endfunction

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	// Mask with a given number of distinct flipped positions, at most two
	function automatic logic [14:0] errorMask(input int count);
		int p1;
		int p2;
		p1 = randBelow(`BCH_N);
		p2 = randBelow(`BCH_N - 1);
		if (p2 >= p1)
			p2++; // Skip p1 so the two positions differ
		if (count == 0)
			return 15'd0;
		else if (count == 1)
			return 15'd1 << p1;
		else
			return (15'd1 << p1) | (15'd1 << p2);
	endfunction

	// Idle for gap cycles and then shift one frame in with the highest power first
	task automatic sendFrame(input logic [6:0] msg, input logic [14:0] mask, input int gap);
		logic [14:0] clean;
		logic [14:0] sent;
		clean = encodeWord(msg);
		sent = clean ^ mask;
		inValid = 1'b0;
		din = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		for (int k = 0; k < `BCH_N; k++) begin
			din = sent[14];
			inValid = 1'b1;
			if (k < `BCH_K) begin
				dueCycleQ.push_back(cycleCnt + `BCH_DELAY);
				dueBitQ.push_back(clean[14]); // The decoder must undo the flip
			end
			sent = sent << 1;
			clean = clean << 1;
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;
		din = 1'b0;
	endtask

	dataCheck: assert property (@(posedge clk) disable iff (rst)
		(dueNow && outValid) |-> (dout == dueBit))
	else begin
		$display("Mismatch at time %0t: dout expected %0b actual %0b",
			$time, $sampled(dueBit), $sampled(dout));
		stopRun();
	end

	spuriousCheck: assert property (@(posedge clk) disable iff (rst)
		outValid |-> dueNow)
	else begin
		$display("Mismatch at time %0t: outValid expected 0 actual %0b",
			$time, $sampled(outValid));
		stopRun();
	end

	missingCheck: assert property (@(posedge clk) disable iff (rst)
		dueNow |-> outValid)
	else begin
		$display("Mismatch at time %0t: outValid expected 1 actual %0b",
			$time, $sampled(outValid));
		stopRun();
	end

	// Between frames the output bit rests at zero
	idleCheck: assert property (@(posedge clk) disable iff (rst)
		!outValid |-> (dout == 1'b0))
	else begin
		$display("Mismatch at time %0t: dout expected 0 actual %0b", $time, $sampled(dout));
		stopRun();
	end

	initial begin
		int waitCnt;
		logic [6:0] msg;
		rst = 1'b1;
		din = 1'b0;
		inValid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Nothing may come out during the quiet period
		repeat (6) begin
			@(posedge clk);
			#1;
		end

		// Clean frames
		for (int i = 0; i < 10; i++) begin
			msg = 7'(randBelow(128));
			sendFrame(msg, 15'd0, randBelow(4));
		end

		// One flipped bit at each of the 15 positions
		for (int p = 0; p < `BCH_N; p++) begin
			msg = 7'(randBelow(128));
			sendFrame(msg, 15'd1 << p, randBelow(3));
		end

		for (int i = 0; i < 30; i++) begin
			msg = 7'(randBelow(128));
			sendFrame(msg, errorMask(2), randBelow(3));
		end

		// Back-to-back runs mixed with idle gaps and any error count up to two
		for (int i = 0; i < 40; i++) begin
			msg = 7'(randBelow(128));
			if (randBelow(2) == 0)
				sendFrame(msg, errorMask(randBelow(3)), 0);
			else
				sendFrame(msg, errorMask(randBelow(3)), 1 + randBelow(5));
		end

		waitCnt = 0;
		while (dueCycleQ.size() > 0 && waitCnt < drainLimit) begin
			@(posedge clk);
			#1;
			waitCnt++;
		end

		if (dueCycleQ.size() != 0) begin
			$display("Timed out after %0d cycles waiting for the last message bits", waitCnt);
			stopRun();
		end else begin
			repeat (4) @(posedge clk); // Let the checks see the final output cycle
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
bchPkg.sv
locatorIf.sv
syndromeCalc.sv
locatorSolve.sv
chienCorrect.sv
bchDecoder.sv
tbBchDecoder.sv

//--- Makefile
# Verilator simulation of the BCH(15,7) decoder testbench

VERILATOR ?= verilator
TOP       ?= tbBchDecoder
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
